// File: common/r5p_cfg_pkg.sv
`default_nettype none

package r5p_cfg_pkg;

  // data path width, fixed for RV32I
  localparam int unsigned XLEN = 32;
  localparam int unsigned XLOG = 5;  // log2(XLEN)

  typedef logic [XLEN-1:0] data_t;   // register value, pc, address
  typedef logic [XLEN-0:0] sum_t;    // adder result plus extension bit
  typedef logic [XLOG-1:0] shamt_t;  // shift amount
  typedef logic [4:0]      ridx_t;   // register index x0..x31

  ////////////////////
  // timing versus area options
  ////////////////////
  localparam bit CFG_LOM = 1'b0;  // dedicated logical operand mux
  localparam bit CFG_SOM = 1'b0;  // dedicated shift amount mux

endpackage: r5p_cfg_pkg

`default_nettype wire

// File: common/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

  ////////////////////
  // major opcodes
  ////////////////////

  // inst[6:2] only, inst[1:0] must be 2'b11 for 32-bit encodings
  typedef enum logic [4:0] {
    LOAD   = 5'b00_000,  // I-type
    STORE  = 5'b01_000,  // S-type
    BRANCH = 5'b11_000,  // B-type
    JALR   = 5'b11_001,  // I-type jump
    JAL    = 5'b11_011,  // J-type jump
    OP_IMM = 5'b00_100,  // I-type alu
    OP     = 5'b01_100,  // R-type alu
    LUI    = 5'b01_101,  // U-type
    AUIPC  = 5'b00_101   // U-type, pc relative
  } opc_t;

  ////////////////////
  // funct3 encodings
  ////////////////////

  // alu operations, shared by OP and OP_IMM
  typedef enum logic [2:0] {
    ADD  = 3'b000,  // add/sub, sub only in OP with f7[5]
    SL   = 3'b001,  // shift left logical
    SLT  = 3'b010,  // set less than
    SLTU = 3'b011,  // set less than unsigned
    XOR  = 3'b100,
    SR   = 3'b101,  // srl/sra by f7[5]
    OR   = 3'b110,
    AND  = 3'b111
  } fn3_alu_t;

  // branch conditions, 3'b010 and 3'b011 are reserved
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } fn3_bru_t;

  // funct7 values seen in the base ISA
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;  // sub, sra, srai

  ////////////////////
  // immediates and decoded control
  ////////////////////

  // all immediates already sign extended to 32 bits
  typedef struct packed {
    r5p_cfg_pkg::data_t i;  // alu imm, jalr offset
    r5p_cfg_pkg::data_t s;  // store offset
    r5p_cfg_pkg::data_t b;  // branch offset, bit 0 zero
    r5p_cfg_pkg::data_t u;  // upper imm, low 12 bits zero
    r5p_cfg_pkg::data_t j;  // jal offset, bit 0 zero
    r5p_cfg_pkg::data_t l;  // load offset, same bits as i
  } imm_t;

  // control word passed from decode to execute
  typedef struct packed {
    opc_t               opc;   // major opcode
    fn3_alu_t           f3;    // alu operation
    logic               f7_5;  // sub / arithmetic shift
    fn3_bru_t           bru;   // branch condition
    r5p_cfg_pkg::ridx_t rd;    // destination index
    logic               ill;   // illegal encoding
    imm_t               imm;
  } ctl_t;

endpackage: riscv_isa_pkg

`default_nettype wire

// File: common/r5p_exe_if.sv
`timescale 1ns/1ps
`default_nettype none

// decode to execute stage, one instruction per vld cycle
interface r5p_exe_if (
  input wire clk  // only for checks in the execute blocks
);
  import riscv_isa_pkg::*;
  import r5p_cfg_pkg::*;

  logic  vld;  // stage holds a valid instruction
  ctl_t  ctl;  // decoded control
  data_t pc;
  data_t rs1;
  data_t rs2;

  // driven by the decode register
  modport dec (
    output vld, ctl, pc, rs1, rs2
  );

  // read by alu, bru and wbu
  modport exe (
    input clk, vld, ctl, pc, rs1, rs2
  );

endinterface: r5p_exe_if

`default_nettype wire

// File: decode/r5p_decode.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_decode (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      in_vld,  // one cycle per instruction
  input  wire [31:0]               inst,
  input  wire r5p_cfg_pkg::data_t  pc,
  input  wire r5p_cfg_pkg::data_t  rs1,
  input  wire r5p_cfg_pkg::data_t  rs2,
  r5p_exe_if.dec                   bus
);
  import riscv_isa_pkg::*;
  import r5p_cfg_pkg::*;

  logic [6:0] f7;   // funct7 field
  logic [2:0] f3;   // funct3 field
  opc_t       opc;
  imm_t       imm;
  logic       ill;
  ctl_t       ctl;

  assign f7  = inst[31:25];
  assign f3  = inst[14:12];
  assign opc = opc_t'(inst[6:2]);

  ////////////////////
  // immediates
  ////////////////////
  assign imm.i = {{20{inst[31]}}, inst[31:20]};
  assign imm.s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm.b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm.u = {inst[31:12], 12'h000};
  assign imm.j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm.l = imm.i;  // loads share the I format

  ////////////////////
  // illegal encodings
  ////////////////////
  always_comb begin
    case (opc)
      LUI, AUIPC, JAL: ill = 1'b0;
      JALR:   ill = (f3 != 3'b000);
      BRANCH: ill = (f3[2:1] == 2'b01);                     // 010, 011 reserved
      LOAD:   ill = (f3 == 3'b011) || (f3[2:1] == 2'b11);   // lb lh lw lbu lhu only
      STORE:  ill = f3[2] || (f3 == 3'b011);                // sb sh sw only
      OP_IMM: begin
        case (f3)
          SL:      ill = (f7 != F7_BASE);                   // shamt[5] must be 0
          SR:      ill = (f7 != F7_BASE) && (f7 != F7_ALT);
          default: ill = 1'b0;                              // imm fills f7
        endcase
      end
      OP:     ill = !((f7 == F7_BASE) || ((f7 == F7_ALT) && ((f3 == ADD) || (f3 == SR))));
      default: ill = 1'b1;  // unknown opcode
    endcase
    if (inst[1:0] != 2'b11) begin
      ill = 1'b1;  // compressed or reserved length
    end
  end

  // control word
  always_comb begin
    ctl.opc  = opc;
    ctl.f3   = fn3_alu_t'(f3);
    ctl.f7_5 = inst[30];
    ctl.bru  = fn3_bru_t'(f3);
    ctl.rd   = ridx_t'(inst[11:7]);
    ctl.ill  = ill;
    ctl.imm  = imm;
  end

  ////////////////////
  // stage register, +1 cycle
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus.vld <= 1'b0;
    end else begin
      bus.vld <= in_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (in_vld) begin  // payload only on a strobe
      bus.ctl <= ctl;
      bus.pc  <= pc;
      bus.rs1 <= rs1;
      bus.rs2 <= rs2;
    end
  end

  // execute blocks rely on a fully known control word
  a_ctl_known: assert property (@(posedge clk) disable iff (!rst_n)
    bus.vld |-> !$isunknown(bus.ctl));

endmodule: r5p_decode

`default_nettype wire

// File: alu/r5p_alu.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_alu (
  r5p_exe_if.exe               bus,
  output r5p_cfg_pkg::data_t   rd,   // alu result
  output r5p_cfg_pkg::sum_t    sum   // adder result with extension bit
);
  import riscv_isa_pkg::*;
  import r5p_cfg_pkg::*;

  data_t  mux_op1;  // shared operand mux
  data_t  mux_op2;
  sum_t   add_op1;  // extended by one bit
  sum_t   add_op2;
  logic   add_inv;  // subtract
  logic   add_sgn;  // signed extension
  data_t  log_op1;
  data_t  log_op2;
  shamt_t shf_sam;  // shift amount
  data_t  shf_tmp;  // shifter input, reversed for left shifts
  data_t  shf_val;

  function automatic sum_t extend(data_t val, logic sgn);
    return sgn ? {val[XLEN-1], val} : {1'b0, val};
  endfunction

  function automatic data_t bitrev(data_t val);
    return {<<{val}};
  endfunction

  ////////////////////
  // adder
  ////////////////////
  always_comb begin
    case (bus.ctl.opc)
      OP, BRANCH:   begin mux_op1 = bus.rs1; mux_op2 = bus.rs2;       end
      OP_IMM, JALR: begin mux_op1 = bus.rs1; mux_op2 = bus.ctl.imm.i; end
      LOAD:         begin mux_op1 = bus.rs1; mux_op2 = bus.ctl.imm.l; end
      STORE:        begin mux_op1 = bus.rs1; mux_op2 = bus.ctl.imm.s; end
      AUIPC:        begin mux_op1 = bus.pc;  mux_op2 = bus.ctl.imm.u; end
      JAL:          begin mux_op1 = bus.pc;  mux_op2 = bus.ctl.imm.j; end
      default:      begin mux_op1 = '0;      mux_op2 = '0;            end
    endcase
  end

  // invert and sign control, branches compare rs1-rs2
  always_comb begin
    add_inv = 1'b0;
    add_sgn = 1'b0;
    case (bus.ctl.opc)
      OP, OP_IMM: begin
        case (bus.ctl.f3)
          ADD:  add_inv = (bus.ctl.opc == OP) && bus.ctl.f7_5;  // sub in R-type only
          SLT:  begin add_inv = 1'b1; add_sgn = 1'b1; end
          SLTU: add_inv = 1'b1;
          default: add_inv = 1'b0;
        endcase
      end
      BRANCH: begin
        add_inv = 1'b1;
        add_sgn = (bus.ctl.bru == BLT) || (bus.ctl.bru == BGE);  // eq/ne don't care
      end
      default: add_inv = 1'b0;  // plain address add
    endcase
  end

  assign add_op1 = extend(mux_op1, add_sgn);
  assign add_op2 = extend(mux_op2, add_sgn);
  assign sum     = add_op1 + (add_inv ? ~add_op2 : add_op2) + sum_t'(add_inv);

  ////////////////////
  // logic and shift operands
  ////////////////////
  if (CFG_LOM) begin: gen_lom_ded
    always_comb begin
      case (bus.ctl.opc)
        OP:      begin log_op1 = bus.rs1; log_op2 = bus.rs2;       end
        OP_IMM:  begin log_op1 = bus.rs1; log_op2 = bus.ctl.imm.i; end
        default: begin log_op1 = '0;      log_op2 = '0;            end
      endcase
    end
  end else begin: gen_lom_shr
    assign log_op1 = add_op1[XLEN-1:0];  // before inversion
    assign log_op2 = add_op2[XLEN-1:0];
  end

  if (CFG_SOM) begin: gen_som_ded
    assign shf_sam = (bus.ctl.opc == OP) ? bus.rs2[XLOG-1:0] : bus.ctl.imm.i[XLOG-1:0];
  end else begin: gen_som_shr
    assign shf_sam = log_op2[XLOG-1:0];
  end

  // one right shifter, left shift by reversing in and out
  assign shf_tmp = (bus.ctl.f3 == SL) ? bitrev(bus.rs1) : bus.rs1;
  assign shf_val = bus.ctl.f7_5 ? data_t'($signed(shf_tmp) >>> shf_sam)  // sra
                                : shf_tmp >> shf_sam;                     // srl, sll

  ////////////////////
  // result mux
  ////////////////////
  always_comb begin
    case (bus.ctl.opc)
      OP, OP_IMM: begin
        case (bus.ctl.f3)
          ADD:       rd = sum[XLEN-1:0];
          SLT, SLTU: rd = data_t'(sum[XLEN]);  // sign of the difference
          AND:       rd = log_op1 & log_op2;
          OR:        rd = log_op1 | log_op2;
          XOR:       rd = log_op1 ^ log_op2;
          SR:        rd = shf_val;
          SL:        rd = bitrev(shf_val);
          default:   rd = '0;
        endcase
      end
      AUIPC:   rd = sum[XLEN-1:0];
      default: rd = '0;  // handled in wbu
    endcase
  end

  // compare ops produce a single bit
  a_slt_bit: assert property (@(posedge bus.clk)
    bus.vld && (bus.ctl.opc inside {OP, OP_IMM}) && (bus.ctl.f3 inside {SLT, SLTU})
    |-> (rd[XLEN-1:1] == '0));

endmodule: r5p_alu

`default_nettype wire

// File: logic/r5p_bru.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_bru (
  r5p_exe_if.exe                  bus,
  input  wire r5p_cfg_pkg::sum_t  sum,     // rs1-rs2 from the alu
  output logic                    jmp,     // control transfer
  output r5p_cfg_pkg::data_t      pc_nxt
);
  import riscv_isa_pkg::*;
  import r5p_cfg_pkg::*;

  logic  eq;     // rs1 == rs2
  logic  lt;     // rs1 < rs2, signedness set by alu
  logic  taken;
  data_t tgt_base;
  data_t tgt_off;
  data_t tgt;    // jump/branch target
  data_t pc_4;

  assign eq = (sum[XLEN-1:0] == '0);
  assign lt = sum[XLEN];

  always_comb begin
    case (bus.ctl.bru)
      BEQ:        taken = eq;
      BNE:        taken = !eq;
      BLT, BLTU:  taken = lt;
      BGE, BGEU:  taken = !lt;
      default:    taken = 1'b0;
    endcase
  end

  ////////////////////
  // target adder, separate from alu
  ////////////////////
  always_comb begin
    tgt_base = bus.pc;
    case (bus.ctl.opc)
      JAL:     tgt_off = bus.ctl.imm.j;
      JALR:    begin tgt_base = bus.rs1; tgt_off = bus.ctl.imm.i; end
      default: tgt_off = bus.ctl.imm.b;
    endcase
  end

  assign tgt  = (tgt_base + tgt_off) & ~data_t'(bus.ctl.opc == JALR);  // jalr clears bit 0
  assign pc_4 = bus.pc + data_t'(4);

  // illegal ops never redirect
  assign jmp = !bus.ctl.ill && ((bus.ctl.opc == JAL) || (bus.ctl.opc == JALR) ||
                                ((bus.ctl.opc == BRANCH) && taken));
  assign pc_nxt = jmp ? tgt : pc_4;

endmodule: r5p_bru

`default_nettype wire

// File: logic/r5p_wbu.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_wbu (
  input  wire                      clk,
  input  wire                      rst_n,
  r5p_exe_if.exe                   bus,
  input  wire r5p_cfg_pkg::data_t  rd_alu,
  input  wire r5p_cfg_pkg::sum_t   sum,       // load/store address
  input  wire                      jmp_c,
  input  wire r5p_cfg_pkg::data_t  pc_nxt_c,
  output logic                     out_vld,   // +2 cycles from in_vld
  output r5p_cfg_pkg::data_t       rd,
  output r5p_cfg_pkg::ridx_t       rd_idx,
  output logic                     rd_we,
  output r5p_cfg_pkg::data_t       adr,
  output r5p_cfg_pkg::data_t       pc_nxt,
  output logic                     jmp,
  output logic                     ill
);
  import riscv_isa_pkg::*;
  import r5p_cfg_pkg::*;

  data_t rd_sel;
  logic  we_c;

  always_comb begin
    case (bus.ctl.opc)
      LUI:       rd_sel = bus.ctl.imm.u;
      JAL, JALR: rd_sel = bus.pc + data_t'(4);  // return address
      LOAD:      rd_sel = '0;                    // data comes later from memory
      default:   rd_sel = rd_alu;
    endcase
  end

  // no write for store, branch, illegal or x0
  assign we_c = !bus.ctl.ill && (bus.ctl.rd != '0) &&
                (bus.ctl.opc inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR, LOAD});

  ////////////////////
  // output register, +2 cycles
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
      rd_we   <= 1'b0;
      jmp     <= 1'b0;
      ill     <= 1'b0;
    end else begin
      out_vld <= bus.vld;
      rd_we   <= bus.vld && we_c;
      jmp     <= bus.vld && jmp_c;
      ill     <= bus.vld && bus.ctl.ill;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.vld) begin  // hold last values between strobes
      rd     <= rd_sel;
      rd_idx <= bus.ctl.rd;
      adr    <= sum[XLEN-1:0];
      pc_nxt <= pc_nxt_c;
    end
  end

  a_we_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_we |-> out_vld);

endmodule: r5p_wbu

`default_nettype wire

// File: logic/r5p_execute.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_execute (
  input  wire                      clk,
  input  wire                      rst_n,
  // instruction in
  input  wire                      in_vld,
  input  wire [31:0]               inst,
  input  wire r5p_cfg_pkg::data_t  pc,
  input  wire r5p_cfg_pkg::data_t  rs1,
  input  wire r5p_cfg_pkg::data_t  rs2,
  // results out
  output logic                     out_vld,
  output r5p_cfg_pkg::data_t       rd,
  output r5p_cfg_pkg::ridx_t       rd_idx,
  output logic                     rd_we,
  output r5p_cfg_pkg::data_t       adr,
  output r5p_cfg_pkg::data_t       pc_nxt,
  output logic                     jmp,
  output logic                     ill
);
  import r5p_cfg_pkg::*;

  data_t rd_alu;    // alu result
  sum_t  sum;       // adder, shared by bru and wbu
  logic  jmp_c;     // unregistered redirect
  data_t pc_nxt_c;

  r5p_exe_if bus (.clk(clk));  // decode to execute stage

  r5p_decode u_dec (
    .clk(clk), .rst_n(rst_n), .in_vld(in_vld), .inst(inst),
    .pc(pc), .rs1(rs1), .rs2(rs2), .bus(bus)
  );

  r5p_alu u_alu (.bus(bus), .rd(rd_alu), .sum(sum));

  r5p_bru u_bru (.bus(bus), .sum(sum), .jmp(jmp_c), .pc_nxt(pc_nxt_c));

  r5p_wbu u_wbu (
    .clk(clk), .rst_n(rst_n), .bus(bus),
    .rd_alu(rd_alu), .sum(sum), .jmp_c(jmp_c), .pc_nxt_c(pc_nxt_c),
    .out_vld(out_vld), .rd(rd), .rd_idx(rd_idx), .rd_we(rd_we),
    .adr(adr), .pc_nxt(pc_nxt), .jmp(jmp), .ill(ill)
  );

endmodule: r5p_execute

`default_nettype wire

// File: bench/r5p_execute_chk.sv
`timescale 1ns/1ps
`default_nettype none

// watches the execute slice where results follow each strobe by 2 cycles
module r5p_execute_chk (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      in_vld,      // strobe as seen by the DUT
  input  wire [31:0]               exp_inst,
  input  wire r5p_cfg_pkg::data_t  exp_rd,
  input  wire                      exp_we,
  input  wire r5p_cfg_pkg::data_t  exp_adr,
  input  wire r5p_cfg_pkg::data_t  exp_pc_nxt,
  input  wire                      exp_jmp,
  input  wire                      exp_ill,
  input  wire                      out_vld,
  input  wire r5p_cfg_pkg::data_t  rd,
  input  wire r5p_cfg_pkg::ridx_t  rd_idx,
  input  wire                      rd_we,
  input  wire r5p_cfg_pkg::data_t  adr,
  input  wire r5p_cfg_pkg::data_t  pc_nxt,
  input  wire                      jmp,
  input  wire                      ill,
  output int                       val_errs,    // wrong output values
  output int                       proto_errs,  // strobe and timing problems
  output int                       checked,
  output int                       pending      // instructions still in flight
);
  import riscv_isa_pkg::*;
  import r5p_cfg_pkg::*;

  typedef struct {
    logic [31:0] inst;
    data_t       rd;
    logic        we;
    data_t       adr;
    data_t       pc_nxt;
    logic        jmp;
    logic        ill;
    int          cyc;  // cycle of the strobe
  } exp_t;

  exp_t q [$];     // expected results in issue order
  int   cyc;
  int   rst_cycles;

  initial begin
    val_errs   = 0;
    proto_errs = 0;
    checked    = 0;
    pending    = 0;
    cyc        = 0;
    rst_cycles = 0;
  end

  task automatic compare(string name, logic [31:0] exp, logic [31:0] got);
    if (got !== exp) begin
      $display("FAIL %s exp=%h got=%h (t=%0t)", name, exp, got, $time);
      val_errs++;
    end
  endtask

  ////////////////////
  // sample on the rising edge with outputs settled from the edge before
  ////////////////////
  always @(posedge clk) begin : watch
    exp_t e;
    cyc = cyc + 1;
    if (!rst_n) begin
      rst_cycles++;
      if (rst_cycles > 1 && {out_vld, rd_we, jmp, ill} !== 4'b0000) begin  // first edge still X
        $display("out_vld, rd_we, jmp or ill is not low during reset (t=%0t)", $time);
        proto_errs++;
      end
    end else begin
      if (in_vld === 1'b1) begin
        q.push_back('{exp_inst, exp_rd, exp_we, exp_adr, exp_pc_nxt, exp_jmp, exp_ill, cyc});
      end
      if (out_vld === 1'b1) begin
        if (q.size() == 0) begin
          $display("out_vld seen with no instruction in flight (t=%0t)", $time);
          proto_errs++;
        end else begin
          e = q.pop_front();
          checked++;
          if (cyc - e.cyc != 2) begin
            $display("out_vld came %0d cycles after in_vld instead of 2 (t=%0t)",
                     cyc - e.cyc, $time);
            proto_errs++;
          end
          compare("rd_we", e.we, rd_we);
          compare("jmp", e.jmp, jmp);
          compare("ill", e.ill, ill);
          compare("pc_nxt", e.pc_nxt, pc_nxt);
          if (e.we) begin  // value and index only matter on a write
            compare("rd", e.rd, rd);
            compare("rd_idx", e.inst[11:7], rd_idx);
          end
          if (opc_t'(e.inst[6:2]) inside {LOAD, STORE}) begin
            compare("adr", e.adr, adr);
          end
        end
      end else if (out_vld !== 1'b0) begin
        $display("out_vld is unknown after reset (t=%0t)", $time);
        proto_errs++;
      end else if ({rd_we, jmp, ill} !== 3'b000) begin
        $display("rd_we, jmp or ill is set while out_vld is low (t=%0t)", $time);
        proto_errs++;
      end
    end
    pending = q.size();
  end

endmodule: r5p_execute_chk

`default_nettype wire

// File: bench/r5p_execute_tb.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_execute_tb;
  import riscv_isa_pkg::*;
  import r5p_cfg_pkg::*;

  // one table row of stimulus then expected results
  typedef struct packed {
    logic [31:0] inst;
    data_t       pc;
    data_t       rs1;
    data_t       rs2;
    data_t       rd;
    logic        we;
    data_t       adr;     // only for load/store
    data_t       pc_nxt;
    logic        jmp;
    logic        ill;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        in_vld;
  logic [31:0] inst;
  data_t       pc;
  data_t       rs1;
  data_t       rs2;
  logic        out_vld;
  data_t       rd;
  ridx_t       rd_idx;
  logic        rd_we;
  data_t       adr;
  data_t       pc_nxt;
  logic        jmp;
  logic        ill;

  entry_t tbl [$];
  entry_t exp_e;      // expected values of the current strobe
  int     seed;
  bit     timed_out;
  int     val_errs;
  int     proto_errs;
  int     checked;
  int     pending;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  r5p_execute DUT (
    .clk(clk), .rst_n(rst_n), .in_vld(in_vld), .inst(inst),
    .pc(pc), .rs1(rs1), .rs2(rs2),
    .out_vld(out_vld), .rd(rd), .rd_idx(rd_idx), .rd_we(rd_we),
    .adr(adr), .pc_nxt(pc_nxt), .jmp(jmp), .ill(ill)
  );

  r5p_execute_chk chk (
    .clk(clk), .rst_n(rst_n), .in_vld(in_vld), .exp_inst(exp_e.inst),
    .exp_rd(exp_e.rd), .exp_we(exp_e.we), .exp_adr(exp_e.adr),
    .exp_pc_nxt(exp_e.pc_nxt), .exp_jmp(exp_e.jmp), .exp_ill(exp_e.ill),
    .out_vld(out_vld), .rd(rd), .rd_idx(rd_idx), .rd_we(rd_we), .adr(adr),
    .pc_nxt(pc_nxt), .jmp(jmp), .ill(ill), .val_errs(val_errs),
    .proto_errs(proto_errs), .checked(checked), .pending(pending)
  );

  ////////////////////
  // instruction encoders with source fields fixed to x1/x2
  ////////////////////
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] dst);
    return {f7, 5'd2, 5'd1, f3, dst, OP, 2'b11};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [2:0] f3, logic [4:0] dst,
                                         opc_t opc);
    return {imm, 5'd1, f3, dst, opc, 2'b11};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], STORE, 2'b11};
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] imm, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], BRANCH, 2'b11};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] dst, opc_t opc);
    return {imm, dst, opc, 2'b11};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] dst);
    return {imm[20], imm[10:1], imm[11], imm[19:12], dst, JAL, 2'b11};
  endfunction

  task automatic full_entry(logic [31:0] i, data_t p, data_t a, data_t b, data_t r,
                            logic w, data_t ad, data_t nxt, logic j, logic il);
    tbl.push_back('{i, p, a, b, r, w, ad, nxt, j, il});
  endtask

  // plain alu op at pc 0x100 that falls through
  task automatic alu_entry(logic [31:0] i, data_t a, data_t b, data_t r, logic w);
    full_entry(i, 'h100, a, b, r, w, 0, 'h104, 1'b0, 1'b0);
  endtask

  task automatic build_table();
    // add, sub and compares with sign boundaries
    alu_entry(r_type(F7_BASE, ADD, 5), 'h7, 'h5, 'hC, 1'b1);
    alu_entry(r_type(F7_ALT, ADD, 5), 'h5, 'h7, 'hFFFF_FFFE, 1'b1);
    alu_entry(r_type(F7_BASE, ADD, 5), 'h7FFF_FFFF, 'h1, 'h8000_0000, 1'b1);
    alu_entry(i_type(12'hFFF, ADD, 5, OP_IMM), 'h0, 'h0, 'hFFFF_FFFF, 1'b1);
    alu_entry(r_type(F7_BASE, SLT, 5), 'h8000_0000, 'h7FFF_FFFF, 'h1, 1'b1);
    alu_entry(r_type(F7_BASE, SLTU, 5), 'h8000_0000, 'h7FFF_FFFF, 'h0, 1'b1);
    alu_entry(r_type(F7_BASE, SLT, 5), 'h1, 'hFFFF_FFFF, 'h0, 1'b1);
    alu_entry(r_type(F7_BASE, SLTU, 5), 'h1, 'hFFFF_FFFF, 'h1, 1'b1);
    alu_entry(i_type(12'h000, SLT, 5, OP_IMM), 'hFFFF_FFFF, 'h0, 'h1, 1'b1);
    alu_entry(i_type(12'hFFF, SLTU, 5, OP_IMM), 'h1, 'h0, 'h1, 1'b1);
    alu_entry(r_type(F7_BASE, ADD, 0), 'h1, 'h2, 'h3, 1'b0);  // x0 so no write
    // logic ops
    alu_entry(r_type(F7_BASE, AND, 5), 'hF0F0_F0F0, 'hFF00_FF00, 'hF000_F000, 1'b1);
    alu_entry(r_type(F7_BASE, OR, 5), 'hF0F0_F0F0, 'hFF00_FF00, 'hFFF0_FFF0, 1'b1);
    alu_entry(r_type(F7_BASE, XOR, 5), 'hF0F0_F0F0, 'hFF00_FF00, 'h0FF0_0FF0, 1'b1);
    alu_entry(i_type(12'h0FF, AND, 5, OP_IMM), 'h1234_5678, 'h0, 'h78, 1'b1);
    alu_entry(i_type(12'h800, OR, 5, OP_IMM), 'h1234_5678, 'h0, 'hFFFF_FE78, 1'b1);
    alu_entry(i_type(12'hFFF, XOR, 5, OP_IMM), 'h1234_5678, 'h0, 'hEDCB_A987, 1'b1);
    // shifts by 0, 1 and 31
    alu_entry(r_type(F7_BASE, SL, 5), 'h8000_0001, 'h1, 'h2, 1'b1);
    alu_entry(r_type(F7_BASE, SL, 5), 'h1, 'h1F, 'h8000_0000, 1'b1);
    alu_entry(r_type(F7_BASE, SL, 5), 'hA5A5_A5A5, 'h0, 'hA5A5_A5A5, 1'b1);
    alu_entry(r_type(F7_BASE, SR, 5), 'h8000_0000, 'h1F, 'h1, 1'b1);
    alu_entry(r_type(F7_BASE, SR, 5), 'h8000_0000, 'h1, 'h4000_0000, 1'b1);
    alu_entry(r_type(F7_BASE, SR, 5), 'hA5A5_A5A5, 'h0, 'hA5A5_A5A5, 1'b1);
    alu_entry(r_type(F7_ALT, SR, 5), 'h8000_0000, 'h1, 'hC000_0000, 1'b1);
    alu_entry(r_type(F7_ALT, SR, 5), 'h8000_0000, 'h1F, 'hFFFF_FFFF, 1'b1);
    alu_entry(r_type(F7_ALT, SR, 5), 'h8000_0000, 'h0, 'h8000_0000, 1'b1);
    alu_entry(i_type(12'h404, SR, 5, OP_IMM), 'hF000_0000, 'h0, 'hFF00_0000, 1'b1);
    alu_entry(i_type(12'h41F, SR, 5, OP_IMM), 'h8000_0000, 'h0, 'hFFFF_FFFF, 1'b1);
    alu_entry(i_type(12'h001, SL, 5, OP_IMM), 'h4000_0001, 'h0, 'h8000_0002, 1'b1);
    // branches at 0x200 with offset +16 unless noted
    full_entry(b_type(13'h010, BEQ), 'h200, 'h5, 'h5, 0, 1'b0, 0, 'h210, 1'b1, 1'b0);
    full_entry(b_type(13'h010, BEQ), 'h200, 'h5, 'h6, 0, 1'b0, 0, 'h204, 1'b0, 1'b0);
    full_entry(b_type(13'h010, BNE), 'h200, 'h5, 'h6, 0, 1'b0, 0, 'h210, 1'b1, 1'b0);
    full_entry(b_type(13'h010, BNE), 'h200, 'h5, 'h5, 0, 1'b0, 0, 'h204, 1'b0, 1'b0);
    full_entry(b_type(13'h010, BLT), 'h200, 'hFFFF_FFFF, 'h1, 0, 1'b0, 0, 'h210, 1'b1, 1'b0);
    full_entry(b_type(13'h010, BLT), 'h200, 'h1, 'hFFFF_FFFF, 0, 1'b0, 0, 'h204, 1'b0, 1'b0);
    full_entry(b_type(13'h010, BGE), 'h200, 'hFFFF_FFFF, 'h1, 0, 1'b0, 0, 'h204, 1'b0, 1'b0);
    full_entry(b_type(13'h010, BGE), 'h200, 'h5, 'h5, 0, 1'b0, 0, 'h210, 1'b1, 1'b0);
    full_entry(b_type(13'h010, BLTU), 'h200, 'hFFFF_FFFF, 'h1, 0, 1'b0, 0, 'h204, 1'b0, 1'b0);
    full_entry(b_type(13'h010, BLTU), 'h200, 'h1, 'hFFFF_FFFF, 0, 1'b0, 0, 'h210, 1'b1, 1'b0);
    full_entry(b_type(13'h010, BGEU), 'h200, 'hFFFF_FFFF, 'h1, 0, 1'b0, 0, 'h210, 1'b1, 1'b0);
    full_entry(b_type(13'h010, BGEU), 'h200, 'h1, 'h2, 0, 1'b0, 0, 'h204, 1'b0, 1'b0);
    full_entry(b_type(13'h1FF8, BNE), 'h200, 'h1, 'h2, 0, 1'b0, 0, 'h1F8, 1'b1, 1'b0);  // back
    // jumps return pc+4
    full_entry(j_type(21'h000800, 1), 'h300, 0, 0, 'h304, 1'b1, 0, 'hB00, 1'b1, 1'b0);
    full_entry(j_type(21'h1FFFFC, 0), 'h300, 0, 0, 0, 1'b0, 0, 'h2FC, 1'b1, 1'b0);
    full_entry(i_type(12'h005, 3'b000, 1, JALR), 'h300, 'h1000, 0, 'h304, 1'b1, 0, 'h1004,
               1'b1, 1'b0);  // odd target loses bit 0
    full_entry(i_type(12'hFFF, 3'b000, 1, JALR), 'h300, 'h1000, 0, 'h304, 1'b1, 0, 'hFFE,
               1'b1, 1'b0);
    // upper immediates and memory addresses
    full_entry(u_type(20'hABCDE, 5, LUI), 'h400, 0, 0, 'hABCD_E000, 1'b1, 0, 'h404, 1'b0, 1'b0);
    full_entry(u_type(20'h00001, 5, AUIPC), 'h400, 0, 0, 'h1400, 1'b1, 0, 'h404, 1'b0, 1'b0);
    full_entry(i_type(12'hFFC, 3'b010, 5, LOAD), 'h400, 'h2000, 0, 0, 1'b1, 'h1FFC, 'h404,
               1'b0, 1'b0);
    full_entry(s_type(12'h010, 3'b010), 'h400, 'h2000, 'h55, 0, 1'b0, 'h2010, 'h404,
               1'b0, 1'b0);
    // illegal encodings never write or redirect
    full_entry(32'hFFFF_FFFF, 'h500, 0, 0, 0, 1'b0, 0, 'h504, 1'b0, 1'b1);
    full_entry(r_type(7'h01, ADD, 5), 'h500, 'h3, 'h4, 0, 1'b0, 0, 'h504, 1'b0, 1'b1);  // mul
    full_entry(b_type(13'h010, 3'b010), 'h500, 'h5, 'h5, 0, 1'b0, 0, 'h504, 1'b0, 1'b1);
    full_entry(i_type(12'h000, 3'b001, 5, JALR), 'h500, 'h40, 0, 0, 1'b0, 0, 'h504, 1'b0, 1'b1);
  endtask

  ////////////////////
  // drivers on the rising edge
  ////////////////////
  task automatic send(entry_t e);
    @(posedge clk);
    in_vld <= 1'b1;
    inst   <= e.inst;
    pc     <= e.pc;
    rs1    <= e.rs1;
    rs2    <= e.rs2;
    exp_e  <= e;
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      in_vld <= 1'b0;
    end
  endtask

  // add, sub and xor on random operands
  task automatic random_alu(int count);
    entry_t e;
    data_t  a;
    data_t  b;
    for (int n = 0; n < count; n++) begin
      a = $random(seed);
      b = $random(seed);
      e = '{r_type(F7_BASE, ADD, 7), 'h600, a, b, 0, 1'b1, 0, 'h604, 1'b0, 1'b0};
      case (n % 3)
        0: e.rd = a + b;
        1: begin
          e.inst = r_type(F7_ALT, ADD, 7);  // sub
          e.rd   = a - b;
        end
        default: begin
          e.inst = r_type(F7_BASE, XOR, 7);
          e.rd   = a ^ b;
        end
      endcase
      send(e);
      if (n % 4 == 3) idle(1);
    end
  endtask

  initial begin
    in_vld    = 1'b0;
    inst      = '0;
    pc        = '0;
    rs1       = '0;
    rs2       = '0;
    exp_e     = '0;
    rst_n     = 1'b0;
    seed      = 46798;
    timed_out = 1'b1;
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    idle(2);  // out_vld must stay low here too
    foreach (tbl[i]) send(tbl[i]);  // back to back
    idle(2);
    foreach (tbl[i]) begin
      send(tbl[i]);
      idle(1 + i % 3);  // uneven gaps
    end
    random_alu(24);
    idle(1);
    // drain the pipe
    for (int w = 0; w < 20 && timed_out; w++) begin
      @(negedge clk);
      if (pending == 0) timed_out = 1'b0;
    end
    if (timed_out) $display("timeout, %0d instructions never got out_vld", pending);
    $display("checked %0d results, value errors %0d, other errors %0d",
             checked, val_errs, proto_errs);
    if (timed_out || val_errs != 0 || proto_errs != 0) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  end

endmodule: r5p_execute_tb

`default_nettype wire

// File: src.f
common/r5p_cfg_pkg.sv
common/riscv_isa_pkg.sv
common/r5p_exe_if.sv
decode/r5p_decode.sv
alu/r5p_alu.sv
logic/r5p_bru.sv
logic/r5p_wbu.sv
logic/r5p_execute.sv
bench/r5p_execute_chk.sv
bench/r5p_execute_tb.sv
